//--- core_pkg.sv
// Shared definitions for the RV64 integer execution core.
// Holds the ISA widths, the major opcodes, the ALU operation encoding
// and the packed records that move between the pipeline stages.
// Every design file refers to these by scoped names.

package core_pkg;

    // ------------------------------------------------------------
    // ISA widths
    // ------------------------------------------------------------

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;

    typedef logic [XLEN-1:0]       xdata_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [INSTR_W-1:0]    instr_t;

    // Major opcodes, bits [6:0] of the instruction.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ------------------------------------------------------------
    // ALU operations
    // ------------------------------------------------------------

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10   // LUI result is the immediate itself
    } alu_op_t;

    // ------------------------------------------------------------
    // Stage records
    // ------------------------------------------------------------

    // Decode stage output, one instruction.
    typedef struct packed {
        logic      valid;
        logic      illegal;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        alu_op_t   alu_op;
        logic      use_imm;
        xdata_t    imm;
    } decoded_t;

    // Writeback record, also the core's result port.
    typedef struct packed {
        logic      valid;
        logic      illegal;
        reg_addr_t rd;
        xdata_t    data;
    } wb_t;

endpackage

//--- decode_stage.sv
// First pipeline stage of the integer core.
// Takes one strobed instruction word per cycle, maps it to an ALU
// operation, builds the sign-extended immediate and registers the
// decoded record. Words outside the kept RV64I subset are flagged illegal.

`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_instr_valid,
    input  core_pkg::instr_t    i_instr,
    output core_pkg::decoded_t  o_dec
);

    // funct7 values of the base and alternate forms.
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // ------------------------------------------------------------
    // Instruction fields
    // ------------------------------------------------------------

    logic [6:0]           s_opcode;
    logic [2:0]           s_funct3;
    logic [6:0]           s_funct7;
    logic [5:0]           s_funct6;
    core_pkg::xdata_t     s_imm_i;
    core_pkg::xdata_t     s_imm_u;
    logic                 s_legal;
    core_pkg::decoded_t   s_dec_next;

    assign s_opcode = i_instr[6:0];
    assign s_funct3 = i_instr[14:12];
    assign s_funct7 = i_instr[31:25];
    // RV64 shifts keep shamt[5] in bit 25, so only the top six bits are checked.
    assign s_funct6 = i_instr[31:26];

    // I-type and U-type immediates, sign-extended to XLEN.
    assign s_imm_i = {{(core_pkg::XLEN-12){i_instr[31]}}, i_instr[31:20]};
    assign s_imm_u = {{(core_pkg::XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    always_comb begin
        s_legal            = 1'b0;
        s_dec_next.rd      = i_instr[11:7];
        s_dec_next.rs1     = i_instr[19:15];
        s_dec_next.rs2     = i_instr[24:20];
        s_dec_next.alu_op  = core_pkg::ALU_ADD;
        s_dec_next.use_imm = 1'b0;
        s_dec_next.imm     = s_imm_i;

        case (s_opcode)
            core_pkg::OPC_OP: begin
                case (s_funct3)
                    3'b000: begin
                        s_legal           = (s_funct7 == F7_BASE) || (s_funct7 == F7_ALT);
                        s_dec_next.alu_op = s_funct7[5] ? core_pkg::ALU_SUB
                                                        : core_pkg::ALU_ADD;
                    end
                    3'b001: begin
                        s_legal           = (s_funct7 == F7_BASE);
                        s_dec_next.alu_op = core_pkg::ALU_SLL;
                    end
                    3'b010: begin
                        s_legal           = (s_funct7 == F7_BASE);
                        s_dec_next.alu_op = core_pkg::ALU_SLT;
                    end
                    3'b011: begin
                        s_legal           = (s_funct7 == F7_BASE);
                        s_dec_next.alu_op = core_pkg::ALU_SLTU;
                    end
                    3'b100: begin
                        s_legal           = (s_funct7 == F7_BASE);
                        s_dec_next.alu_op = core_pkg::ALU_XOR;
                    end
                    3'b101: begin
                        s_legal           = (s_funct7 == F7_BASE) || (s_funct7 == F7_ALT);
                        s_dec_next.alu_op = s_funct7[5] ? core_pkg::ALU_SRA
                                                        : core_pkg::ALU_SRL;
                    end
                    3'b110: begin
                        s_legal           = (s_funct7 == F7_BASE);
                        s_dec_next.alu_op = core_pkg::ALU_OR;
                    end
                    default: begin
                        s_legal           = (s_funct7 == F7_BASE);
                        s_dec_next.alu_op = core_pkg::ALU_AND;
                    end
                endcase
            end

            core_pkg::OPC_OP_IMM: begin
                s_dec_next.use_imm = 1'b1;
                // No second source register.
                s_dec_next.rs2     = '0;
                s_legal            = 1'b1;
                case (s_funct3)
                    3'b000: s_dec_next.alu_op = core_pkg::ALU_ADD;
                    3'b001: begin
                        s_legal           = (s_funct6 == F7_BASE[6:1]);
                        s_dec_next.alu_op = core_pkg::ALU_SLL;
                    end
                    3'b010: s_dec_next.alu_op = core_pkg::ALU_SLT;
                    3'b011: s_dec_next.alu_op = core_pkg::ALU_SLTU;
                    3'b100: s_dec_next.alu_op = core_pkg::ALU_XOR;
                    3'b101: begin
                        // ALU sees only imm[5:0], so bit 10 of SRAI does no harm.
                        s_legal           = (s_funct6 == F7_BASE[6:1]) ||
                                            (s_funct6 == F7_ALT[6:1]);
                        s_dec_next.alu_op = s_funct6[4] ? core_pkg::ALU_SRA
                                                        : core_pkg::ALU_SRL;
                    end
                    3'b110: s_dec_next.alu_op = core_pkg::ALU_OR;
                    default: s_dec_next.alu_op = core_pkg::ALU_AND;
                endcase
            end

            core_pkg::OPC_LUI: begin
                s_legal            = 1'b1;
                // Index zero reads zero, which gives operand a of zero.
                s_dec_next.rs1     = '0;
                s_dec_next.rs2     = '0;
                s_dec_next.alu_op  = core_pkg::ALU_PASS_B;
                s_dec_next.use_imm = 1'b1;
                s_dec_next.imm     = s_imm_u;
            end

            default: s_legal = 1'b0;
        endcase

        s_dec_next.valid   = i_instr_valid & s_legal;
        s_dec_next.illegal = i_instr_valid & ~s_legal;
    end

    // ------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        o_dec <= s_dec_next;
        if (i_rst) begin
            o_dec.valid   <= 1'b0;
            o_dec.illegal <= 1'b0;
        end
    end

endmodule

//--- reg_file.sv
// Architectural register file of the integer core.
// Two combinational read ports and one write port fed by the
// writeback record. Register zero is not stored and always reads zero.

`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                i_rst,
    input  core_pkg::reg_addr_t i_raddr_a,
    input  core_pkg::reg_addr_t i_raddr_b,
    output core_pkg::xdata_t    o_rdata_a,
    output core_pkg::xdata_t    o_rdata_b,
    input  core_pkg::wb_t       i_wb
);

    localparam int NUM_REGS = 2 ** core_pkg::REG_ADDR_W;

    // Registers one and up.
    core_pkg::xdata_t s_regs [1:NUM_REGS-1];
    logic             s_write_en;

    // Only legal results to a nonzero index are committed.
    assign s_write_en = i_wb.valid & ~i_wb.illegal & (i_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                s_regs[i] <= '0;
            end
        end else if (s_write_en) begin
            s_regs[i_wb.rd] <= i_wb.data;
        end
    end

    // Read ports.
    assign o_rdata_a = (i_raddr_a == '0) ? '0 : s_regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : s_regs[i_raddr_b];

endmodule

//--- alu.sv
// Combinational RV64 integer ALU.
// Covers add, subtract, shifts, compares and logic ops, plus a pass of
// operand b for LUI. Shift amounts come from the low six bits of b.

`timescale 1ns/1ps

module alu (
    input  core_pkg::alu_op_t i_op,
    input  core_pkg::xdata_t  i_src_a,
    input  core_pkg::xdata_t  i_src_b,
    output core_pkg::xdata_t  o_result
);

    logic [5:0] s_shamt;
    logic       s_lt_signed;
    logic       s_lt_unsigned;

    assign s_shamt = i_src_b[5:0];

    // Compare results.
    assign s_lt_signed   = $signed(i_src_a) < $signed(i_src_b);
    assign s_lt_unsigned = i_src_a < i_src_b;

    always_comb begin
        case (i_op)
            core_pkg::ALU_ADD: begin
                o_result = i_src_a + i_src_b;
            end
            core_pkg::ALU_SUB: begin
                o_result = i_src_a - i_src_b;
            end
            core_pkg::ALU_SLL: begin
                o_result = i_src_a << s_shamt;
            end
            core_pkg::ALU_SLT: begin
                o_result = {{(core_pkg::XLEN-1){1'b0}}, s_lt_signed};
            end
            core_pkg::ALU_SLTU: begin
                o_result = {{(core_pkg::XLEN-1){1'b0}}, s_lt_unsigned};
            end
            core_pkg::ALU_XOR: begin
                o_result = i_src_a ^ i_src_b;
            end
            core_pkg::ALU_SRL: begin
                o_result = i_src_a >> s_shamt;
            end
            core_pkg::ALU_SRA: begin
                // Arithmetic shift keeps the sign of operand a.
                o_result = core_pkg::xdata_t'($signed(i_src_a) >>> s_shamt);
            end
            core_pkg::ALU_OR: begin
                o_result = i_src_a | i_src_b;
            end
            core_pkg::ALU_AND: begin
                o_result = i_src_a & i_src_b;
            end
            core_pkg::ALU_PASS_B: begin
                o_result = i_src_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- execute_stage.sv
// Second pipeline stage of the integer core.
// Reads the source registers, forwards the result still waiting in the
// writeback record, runs the ALU and registers the writeback record.
// The same record drives the register file write port and the outputs.

`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                i_rst,
    input  core_pkg::decoded_t  i_dec,
    output core_pkg::reg_addr_t o_raddr_a,
    output core_pkg::reg_addr_t o_raddr_b,
    input  core_pkg::xdata_t    i_rdata_a,
    input  core_pkg::xdata_t    i_rdata_b,
    output core_pkg::wb_t       o_wb
);

    logic              s_wb_commit;
    logic              s_fwd_a;
    logic              s_fwd_b;
    core_pkg::xdata_t  s_rs1_val;
    core_pkg::xdata_t  s_rs2_val;
    core_pkg::xdata_t  s_src_b;
    core_pkg::xdata_t  s_alu_result;
    core_pkg::wb_t     s_wb_next;

    // Register file read addresses.
    assign o_raddr_a = i_dec.rs1;
    assign o_raddr_b = i_dec.rs2;

    // ------------------------------------------------------------
    // Writeback bypass
    // ------------------------------------------------------------

    // The record ahead is written to the file at the next edge, so
    // its value is not in the file yet.
    assign s_wb_commit = o_wb.valid & ~o_wb.illegal & (o_wb.rd != '0);
    assign s_fwd_a     = s_wb_commit & (o_wb.rd == i_dec.rs1);
    assign s_fwd_b     = s_wb_commit & (o_wb.rd == i_dec.rs2);

    assign s_rs1_val = s_fwd_a ? o_wb.data : i_rdata_a;
    assign s_rs2_val = s_fwd_b ? o_wb.data : i_rdata_b;

    // Operand a is zero for LUI, since decode sets rs1 to zero.
    assign s_src_b = i_dec.use_imm ? i_dec.imm : s_rs2_val;

    alu u_alu (
        .i_op     ( i_dec.alu_op ),
        .i_src_a  ( s_rs1_val    ),
        .i_src_b  ( s_src_b      ),
        .o_result ( s_alu_result )
    );

    // ------------------------------------------------------------
    // Writeback register
    // ------------------------------------------------------------

    assign s_wb_next.valid   = i_dec.valid;
    assign s_wb_next.illegal = i_dec.illegal;
    assign s_wb_next.rd      = i_dec.rd;
    assign s_wb_next.data    = s_alu_result;

    always_ff @(posedge clk) begin
        o_wb <= s_wb_next;
        if (i_rst) begin
            o_wb.valid   <= 1'b0;
            o_wb.illegal <= 1'b0;
        end
    end

endmodule

//--- rv_exec_core.sv
// Top level of the three-stage RV64I integer execution core.
// Instructions enter on a plain strobe, one per cycle at most, and each
// leaves two edges later as a writeback pulse or an illegal pulse.

`timescale 1ns/1ps

module rv_exec_core (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_instr_valid,
    input  core_pkg::instr_t    i_instr,
    output logic                o_wb_valid,
    output core_pkg::reg_addr_t o_wb_rd,
    output core_pkg::xdata_t    o_wb_data,
    output logic                o_illegal
);

    core_pkg::decoded_t  s_dec;
    core_pkg::wb_t       s_wb;
    core_pkg::reg_addr_t s_raddr_a;
    core_pkg::reg_addr_t s_raddr_b;
    core_pkg::xdata_t    s_rdata_a;
    core_pkg::xdata_t    s_rdata_b;

    decode_stage u_decode (
        .clk           ( clk           ),
        .i_rst         ( i_rst         ),
        .i_instr_valid ( i_instr_valid ),
        .i_instr       ( i_instr       ),
        .o_dec         ( s_dec         )
    );

    execute_stage u_execute (
        .clk       ( clk       ),
        .i_rst     ( i_rst     ),
        .i_dec     ( s_dec     ),
        .o_raddr_a ( s_raddr_a ),
        .o_raddr_b ( s_raddr_b ),
        .i_rdata_a ( s_rdata_a ),
        .i_rdata_b ( s_rdata_b ),
        .o_wb      ( s_wb      )
    );

    reg_file u_reg_file (
        .clk       ( clk       ),
        .i_rst     ( i_rst     ),
        .i_raddr_a ( s_raddr_a ),
        .i_raddr_b ( s_raddr_b ),
        .o_rdata_a ( s_rdata_a ),
        .o_rdata_b ( s_rdata_b ),
        .i_wb      ( s_wb      )
    );

    // Result port.
    assign o_wb_valid = s_wb.valid;
    assign o_wb_rd    = s_wb.rd;
    assign o_wb_data  = s_wb.data;
    assign o_illegal  = s_wb.illegal;

endmodule

//--- tb_ref_model.svh
// Reference side of the core testbench, included inside the testbench module.
// Holds the random number generator, the instruction encoder and an
// architectural model of the 32 integer registers.

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Funct3 of the ten integer operations.
// Order is ADD SUB SLL SLT SLTU XOR SRL SRA OR AND.
localparam logic [2:0] FUNCT3_TAB [10] = '{
    3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7
};

logic [31:0]      lcg_state = 32'd46;
core_pkg::xdata_t model_regs [32];

// Linear congruential generator, full 32-bit state.
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Upper half only, the low bits of an LCG repeat quickly.
function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];
endfunction

// Architectural result of one integer operation.
function automatic core_pkg::xdata_t model_result(input int op, input core_pkg::xdata_t a,
                                                  input core_pkg::xdata_t b);
    case (op)
        0: return a + b;
        1: return a - b;
        2: return a << b[5:0];
        3: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        4: return (a < b) ? 64'd1 : 64'd0;
        5: return a ^ b;
        6: return a >> b[5:0];
        7: return $signed(a) >>> b[5:0];
        8: return a | b;
        default: return a & b;
    endcase
endfunction

// Encodes one instruction and executes it on the model.
// Kinds 0-9 are register ops, 10-19 immediate ops, 20 an illegal word.
function automatic void make_instr(input int kind, input core_pkg::reg_addr_t rd,
                                   input core_pkg::reg_addr_t rs1,
                                   input core_pkg::reg_addr_t rs2, input logic [19:0] imm,
                                   output core_pkg::instr_t word, output core_pkg::wb_t exp);
    int               op;
    logic [11:0]      imm12;
    core_pkg::xdata_t b;
    op     = kind % 10;
    imm12  = imm[11:0];
    exp    = '0;
    exp.rd = rd;
    if (kind == 20) begin
        exp.illegal = 1'b1;
        case (imm[1:0])
            2'd0: word = {imm, rd, 7'b0000011};
            2'd1: word = {7'h01, rs2, rs1, 3'd0, rd, core_pkg::OPC_OP};
            2'd2: word = {6'b000001, imm[5:0], rs1, 3'd1, rd, core_pkg::OPC_OP_IMM};
            default: word = {7'h20, rs2, rs1, 3'd4, rd, core_pkg::OPC_OP};
        endcase
    end else if (kind == 11) begin
        // LUI takes the SUB slot, there is no immediate subtract.
        word      = {imm, rd, core_pkg::OPC_LUI};
        exp.valid = 1'b1;
        exp.data  = {{32{imm[19]}}, imm, 12'h000};
    end else begin
        if (kind < 10) begin
            word = {(op == 1 || op == 7) ? 7'h20 : 7'h00, rs2, rs1, FUNCT3_TAB[op], rd,
                    core_pkg::OPC_OP};
            b    = model_regs[rs2];
        end else begin
            // Shift immediates carry a six-bit amount.
            if (op == 2 || op == 6 || op == 7) begin
                imm12 = {(op == 7) ? 6'b010000 : 6'b000000, imm[5:0]};
            end
            word = {imm12, rs1, FUNCT3_TAB[op], rd, core_pkg::OPC_OP_IMM};
            b    = {{52{imm12[11]}}, imm12};
        end
        exp.valid = 1'b1;
        exp.data  = model_result(op, model_regs[rs1], b);
    end
    if (exp.valid && rd != 5'd0) begin
        model_regs[rd] = exp.data;
    end
endfunction

// Random instruction, half of the sources reuse the previous rd.
function automatic void random_instr(input core_pkg::reg_addr_t prev_rd,
                                     output core_pkg::instr_t word,
                                     output core_pkg::wb_t exp);
    logic [15:0]         r;
    logic [31:0]         imm_bits;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    int                  kind;
    r        = rand16();
    imm_bits = {rand16(), rand16()};
    kind     = int'(rand16()) % 21;
    rs1      = imm_bits[31] ? prev_rd : r[9:5];
    rs2      = imm_bits[30] ? prev_rd : r[14:10];
    make_instr(kind, r[4:0], rs1, rs2, imm_bits[19:0], word, exp);
endfunction

`endif

//--- tb_core.sv
// Testbench for the three-stage RV64I integer execution core.
// Drives directed and random instruction streams, predicts each result
// with a register model and checks every output cycle two cycles later.

`timescale 1ns/1ps

module tb_core;

    localparam int NUM_RANDOM = 2000;
    // 2000 random instructions, about 250 gap cycles and the directed parts.
    localparam int CYCLE_LIMIT = 3000;

    logic                clk;
    logic                i_rst;
    logic                i_instr_valid;
    core_pkg::instr_t    i_instr;
    logic                o_wb_valid;
    core_pkg::reg_addr_t o_wb_rd;
    core_pkg::xdata_t    o_wb_data;
    logic                o_illegal;

    // Holds one expected record for every driven cycle.
    core_pkg::wb_t exp_q [$];
    int            cycle_count = 0;

    `include "tb_ref_model.svh"

    rv_exec_core dut (
        .clk           ( clk           ),
        .i_rst         ( i_rst         ),
        .i_instr_valid ( i_instr_valid ),
        .i_instr       ( i_instr       ),
        .o_wb_valid    ( o_wb_valid    ),
        .o_wb_rd       ( o_wb_rd       ),
        .o_wb_data     ( o_wb_data     ),
        .o_illegal     ( o_illegal     )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        if (got !== exp) begin
            $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_wb(input core_pkg::wb_t exp);
        compare_field("o_wb_valid", 64'(exp.valid), 64'(o_wb_valid));
        compare_field("o_illegal", 64'(exp.illegal), 64'(o_illegal));
        compare_field("o_wb_rd", 64'(exp.rd), 64'(o_wb_rd));
        compare_field("o_wb_data", exp.data, o_wb_data);
    endtask

    task automatic check_illegal(input core_pkg::wb_t exp);
        compare_field("o_wb_valid", 64'(exp.valid), 64'(o_wb_valid));
        compare_field("o_illegal", 64'(exp.illegal), 64'(o_illegal));
    endtask

    task automatic check_idle(input core_pkg::wb_t exp);
        compare_field("o_wb_valid", 64'(exp.valid), 64'(o_wb_valid));
        compare_field("o_illegal", 64'(exp.illegal), 64'(o_illegal));
    endtask

    // Checks the record due now, then drives the next input.
    task automatic step(input logic valid, input core_pkg::instr_t word,
                        input core_pkg::wb_t exp);
        core_pkg::wb_t due;
        @(posedge clk);
        #1;
        if (exp_q.size() == 2) begin
            due = exp_q.pop_front();
            if (due.valid) begin
                check_wb(due);
            end else if (due.illegal) begin
                check_illegal(due);
            end else begin
                check_idle(due);
            end
        end else begin
            // Nothing is in flight yet, so both pulses stay low.
            check_idle('0);
        end
        i_instr_valid = valid;
        i_instr       = word;
        exp_q.push_back(exp);
    endtask

    task automatic idle_step();
        step(1'b0, '0, '0);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
            stop_on_failure();
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    initial begin
        core_pkg::instr_t    word;
        core_pkg::wb_t       exp;
        core_pkg::reg_addr_t prev_rd;
        core_pkg::reg_addr_t rd;
        logic [15:0]         r;
        int                  kind;

        i_rst         = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        prev_rd       = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        i_rst = 1'b0;

        // Quiet outputs, then every register reads zero.
        repeat (5) idle_step();
        for (int i = 1; i < 32; i++) begin
            make_instr(10, 5'(i), 5'(i), 5'd0, 20'd0, word, exp);
            step(1'b1, word, exp);
        end

        // Random mix with occasional gaps.
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_instr(prev_rd, word, exp);
            prev_rd = word[11:7];
            step(1'b1, word, exp);
            r = rand16();
            if (r[2:0] == 3'd0) begin
                idle_step();
            end
        end

        // Dependent chains with zero to two idle cycles between links.
        for (int gap = 0; gap < 3; gap++) begin
            repeat (8) begin
                r    = rand16();
                kind = int'(r[15:8]) % 20;
                rd   = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
                make_instr(kind, rd, prev_rd, prev_rd, {r[3:0], rand16()}, word, exp);
                prev_rd = rd;
                step(1'b1, word, exp);
                repeat (gap) idle_step();
            end
        end

        // Drain the last two results.
        repeat (2) idle_step();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
core_pkg.sv
decode_stage.sv
reg_file.sv
alu.sv
execute_stage.sv
rv_exec_core.sv
tb_core.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps -Wall
TOP        = tb_core
FILELIST   = verilog.f
LOG        = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "No pass line in log"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
